// ==== all.f ====
verilog/bpPkg.sv
verilog/bpIfs.sv
verilog/asyncRam.sv
verilog/historyNext.sv
verilog/targetCache.sv
verilog/historyTable.sv
verilog/pairPredictor.sv
testbench/tbPairPredictor.sv

// ==== Makefile ====
# Verilator build and run of the pair predictor testbench

VERILATOR ?= verilator
TOP       ?= tbPairPredictor
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tbPairPredictor.sv ====
/*
 * Testbench of the pair predictor with a reference model of the target
 * cache and the history table. Fetch outputs are checked on every cycle,
 * 1 ns after the falling edge. PCs come from a small pool of tags and sets
 * so that builds, hits and conflicts happen often.
 */
`timescale 1ns/100ps
`default_nettype none

module tbPairPredictor;
    import bpPkg::*;

    localparam int SET_BITS      = 5;
    localparam int TAG_WIDTH     = 24;
    localparam int HIST_IDX_BITS = 6;
    localparam int TIMEOUT_NS    = 100000;

    logic        clk, rstn;
    logic        bldValid, resValid, resTaken, resBack;
    logic [31:0] bldPc, bldTargetLower, bldTargetUpper, resPc, fetchPc;
    branchKind_e bldKindLower, bldKindUpper, resKind;
    logic        predHitLower, predHitUpper, predTakenLower, predTakenUpper;
    branchKind_e predKindLower, predKindUpper;
    logic [31:0] predTargetLower, predTargetUpper;

    // staged request, applied at the next falling edge
    logic        sBv, sRv, sRt, sRb;
    logic [31:0] sBpc, sTl, sTu, sRpc, sFpc;
    branchKind_e sKl, sKu, sRk;

    // reference model state
    logic        cValidL [32], cValidU [32];
    logic [23:0] cTagL [32], cTagU [32];
    branchKind_e cKindL [32], cKindU [32];
    logic [31:0] cTgtL [32], cTgtU [32];
    logic        hValid [64];
    logic [1:0]  hHist [64];
    logic [1:0]  hCtr [64][4];

    logic [31:0] lfsr = 32'h554c641a;
    logic [31:0] condPc, jmpPc, prevPc, newPc;

    pairPredictor #(
        .SET_BITS(SET_BITS), .TAG_WIDTH(TAG_WIDTH), .HIST_IDX_BITS(HIST_IDX_BITS)
    ) uut (.*);

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'ha3000000 : lfsr >> 1;   // galois step
        end
        return v;
    endfunction

    function automatic logic [31:0] poolPc(input logic [1:0] tagSel, input logic [2:0] set,
                                           input logic slot);
        return {22'h2d5a3c, tagSel, 2'b00, set, slot, 2'b00};
    endfunction

    function automatic logic isCachedKind(input branchKind_e k);
        return (k == kCond) || (k == kJump);
    endfunction

    task automatic stopOnFailure(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic stageBuild(input logic [31:0] pc, input branchKind_e kl,
                              input branchKind_e ku);
        sBv  = 1'b1;
        sBpc = pc;
        sKl  = kl;
        sKu  = ku;
        sTl  = randBits(32);
        sTu  = randBits(32);
    endtask

    task automatic stageResolve(input logic [31:0] pc, input logic taken,
                                input branchKind_e kind);
        sRv  = 1'b1;
        sRpc = pc;
        sRt  = taken;
        sRb  = 1'(randBits(1));
        sRk  = kind;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////
    task automatic expectSlot(input logic [31:0] pc, input logic upper, output logic eHit,
                              output branchKind_e eKind, output logic [31:0] eTgt,
                              output logic eTaken);
        logic [4:0]  set;
        logic [5:0]  idx;
        branchKind_e kind;
        set   = pc[7:3];
        idx   = {set, upper};
        eHit  = upper ? cValidU[set] && (cTagU[set] === pc[31:8])
                      : cValidL[set] && (cTagL[set] === pc[31:8]);
        kind  = upper ? cKindU[set] : cKindL[set];
        eKind = eHit ? kind : kNone;
        eTgt  = upper ? {cTgtU[set][31:2], 2'b00} : {cTgtL[set][31:2], 2'b00};
        eTaken = eHit && (kind == kJump || (hValid[idx] && hCtr[idx][hHist[idx]] >= 2));
    endtask

    task automatic applyRequests();
        logic [4:0] bset, rset;
        logic [5:0] ridx;
        logic       present, replace, rhit;
        logic [1:0] c;
        bset    = sBpc[7:3];
        rset    = sRpc[7:3];
        ridx    = sRpc[7:2];
        present = (isCachedKind(sKl) && cValidL[bset] && cTagL[bset] === sBpc[31:8])
               || (isCachedKind(sKu) && cValidU[bset] && cTagU[bset] === sBpc[31:8]);
        replace = sBv && !present;
        rhit    = sRpc[2] ? cValidU[rset] && cTagU[rset] === sRpc[31:8]
                          : cValidL[rset] && cTagL[rset] === sRpc[31:8];
        if (sRv && rhit) begin
            if (hValid[ridx]) begin
                c = hCtr[ridx][hHist[ridx]];
                if (sRt && c != 2'd3) begin
                    c = c + 2'd1;
                end else if (!sRt && c != 2'd0) begin
                    c = c - 2'd1;
                end
                hCtr[ridx][hHist[ridx]] = c;
                hHist[ridx] = {hHist[ridx][0], sRt};
            end else if (sRk == kCond) begin
                hHist[ridx] = {sRb, sRt};
                hCtr[ridx]  = '{2'd1, sRb ? 2'd2 : 2'd1, sRb ? 2'd2 : 2'd1, 2'd2};
            end else if (sRk == kNone) begin
                hHist[ridx] = 2'd0;
                hCtr[ridx]  = '{2'd0, 2'd0, 2'd0, 2'd0};
            end else begin
                hHist[ridx] = 2'd3;
                hCtr[ridx]  = '{2'd3, 2'd3, 2'd3, 2'd3};
            end
            hValid[ridx] = 1'b1;
        end
        if (replace) begin
            hValid[{bset, 1'b0}] = 1'b0;   // erase beats the resolve
            hValid[{bset, 1'b1}] = 1'b0;
            cValidL[bset] = isCachedKind(sKl);
            cValidU[bset] = isCachedKind(sKu);
            cTagL[bset]   = sBpc[31:8];
            cTagU[bset]   = sBpc[31:8];
            cKindL[bset]  = sKl;
            cKindU[bset]  = sKu;
            cTgtL[bset]   = sTl;
            cTgtU[bset]   = sTu;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checking and cycle driver
    ////////////////////////////////////////////////////////////////////////////
    task automatic checkSlot(input string name, input logic gHit, input branchKind_e gKind,
                             input logic [31:0] gTgt, input logic gTaken, input logic eHit,
                             input branchKind_e eKind, input logic [31:0] eTgt,
                             input logic eTaken);
        assert (gHit === eHit) else stopOnFailure($sformatf(
            "ERR time %0t: %s hit %b, expected %b, pc %h", $time, name, gHit, eHit, fetchPc));
        assert (gKind === eKind) else stopOnFailure($sformatf(
            "ERR time %0t: %s kind %0d, expected %0d, pc %h", $time, name, gKind, eKind,
            fetchPc));
        assert (!eHit || gTgt === eTgt) else stopOnFailure($sformatf(
            "ERR time %0t: %s target %h, expected %h", $time, name, gTgt, eTgt));
        assert (gTaken === eTaken) else stopOnFailure($sformatf(
            "ERR time %0t: %s taken %b, expected %b, pc %h", $time, name, gTaken, eTaken,
            fetchPc));
    endtask

    task automatic checkFetch();
        logic        eHit, eTaken;
        branchKind_e eKind;
        logic [31:0] eTgt;
        expectSlot(fetchPc, 1'b0, eHit, eKind, eTgt, eTaken);
        checkSlot("lower", predHitLower, predKindLower, predTargetLower, predTakenLower,
                  eHit, eKind, eTgt, eTaken);
        expectSlot(fetchPc, 1'b1, eHit, eKind, eTgt, eTaken);
        checkSlot("upper", predHitUpper, predKindUpper, predTargetUpper, predTakenUpper,
                  eHit, eKind, eTgt, eTaken);
    endtask

    task automatic runCycle();
        @(negedge clk);
        bldValid       = sBv;
        bldPc          = sBpc;
        bldKindLower   = sKl;
        bldKindUpper   = sKu;
        bldTargetLower = sTl;
        bldTargetUpper = sTu;
        resValid       = sRv;
        resPc          = sRpc;
        resTaken       = sRt;
        resBack        = sRb;
        resKind        = sRk;
        fetchPc        = sFpc;
        #1;
        checkFetch();
        @(posedge clk);
        applyRequests();
        sBv = 1'b0;
        sRv = 1'b0;
    endtask

    initial begin
        #(TIMEOUT_NS);
        stopOnFailure("timeout: the testbench did not reach its end");
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        clk            = 1'b0;
        rstn           = 1'b0;
        bldValid       = 1'b0;
        bldPc          = '0;
        bldKindLower   = kNone;
        bldKindUpper   = kNone;
        bldTargetLower = '0;
        bldTargetUpper = '0;
        resValid       = 1'b0;
        resPc          = '0;
        resTaken       = 1'b0;
        resBack        = 1'b0;
        resKind        = kNone;
        fetchPc        = '0;
        {sBv, sRv, sRt, sRb} = '0;
        {sBpc, sTl, sTu, sRpc, sFpc} = '0;
        sKl = kNone;
        sKu = kNone;
        sRk = kNone;
        for (int i = 0; i < 32; i++) begin
            cValidL[i] = 1'b0;
            cValidU[i] = 1'b0;
        end
        for (int i = 0; i < 64; i++) begin
            hValid[i] = 1'b0;
        end
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
        end
        rstn = 1'b1;

        repeat (8) begin                           // empty after reset
            sFpc = randBits(32);
            runCycle();
        end
        prevPc = poolPc(2'd0, 3'd0, 1'b0);
        for (int i = 0; i < 40; i++) begin         // builds, other tag on odd cycles
            sFpc = i[0] ? prevPc ^ 32'h100 : prevPc;
            prevPc = poolPc(2'(randBits(2)), 3'(randBits(3)), 1'b0);
            stageBuild(prevPc, branchKind_e'(randBits(2)), branchKind_e'(randBits(2)));
            runCycle();
        end
        condPc = poolPc(2'd3, 3'd5, 1'b0);
        sFpc = condPc;
        stageBuild(condPc, kCond, kCond);
        runCycle();
        for (int i = 0; i < 200; i++) begin        // biased runs reach both saturations
            stageResolve(condPc | (randBits(1) << 2),
                         ((i / 25) % 2 == 1) ? randBits(2) != 0 : randBits(2) == 0, kCond);
            runCycle();
        end
        jmpPc = poolPc(2'd2, 3'd6, 1'b0);
        sFpc = jmpPc;
        stageBuild(jmpPc, kJump, kCond);
        runCycle();
        for (int i = 0; i < 40; i++) begin         // jump slot and resolves that miss
            if (i[0]) begin
                stageResolve(jmpPc ^ 32'h80000000 ^ (randBits(1) << 2),
                             1'(randBits(1)), kCond);
            end else begin
                stageResolve(jmpPc | 32'h4, 1'(randBits(1)), kCond);
            end
            runCycle();
        end
        sFpc = condPc;
        stageBuild(condPc, kCond, kCond);          // present pair keeps its history
        runCycle();
        runCycle();
        newPc = poolPc(2'd1, 3'd5, 1'b0);
        stageBuild(newPc, kCond, kJump);           // conflict with resolve to erased slot
        stageResolve(condPc, 1'(randBits(1)), kCond);
        runCycle();
        sFpc = newPc;
        for (int i = 0; i < 20; i++) begin
            stageResolve(newPc | (randBits(1) << 2), 1'(randBits(1)), kCond);
            runCycle();
        end
        for (int i = 0; i < 300; i++) begin        // mixed traffic over the pool
            if (randBits(2) == 0) begin
                stageBuild(poolPc(2'(randBits(2)), 3'(randBits(3)), 1'b0),
                           branchKind_e'(randBits(2)), branchKind_e'(randBits(2)));
            end
            if (randBits(1) != 0) begin
                stageResolve(poolPc(2'(randBits(2)), 3'(randBits(3)), 1'(randBits(1))),
                             1'(randBits(1)), branchKind_e'(randBits(2)));
            end
            sFpc = poolPc(2'(randBits(2)), 3'(randBits(3)), 1'b0);
            runCycle();
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/pairPredictor.sv ====
/*
 * Pair-fetch branch predictor top, plain ports onto the internal bundles.
 * Fetch outputs are combinational from fetchPc; builds and resolves
 * are seen from the cycle after their valid pulse.
 * HIST_IDX_BITS must equal SET_BITS + 1.
 */
`timescale 1ns/100ps
`default_nettype none

module pairPredictor #(
    parameter int SET_BITS      = 5,
    parameter int TAG_WIDTH     = 24,
    parameter int HIST_IDX_BITS = 6
)(
    input  wire                               clk,
    input  wire                               rstn,
    // decode-time build
    input  wire                               bldValid,
    input  wire  [bpPkg::ADDR_WIDTH-1:0]      bldPc,
    input  wire  bpPkg::branchKind_e          bldKindLower,
    input  wire  bpPkg::branchKind_e          bldKindUpper,
    input  wire  [bpPkg::ADDR_WIDTH-1:0]      bldTargetLower,
    input  wire  [bpPkg::ADDR_WIDTH-1:0]      bldTargetUpper,
    // execute-time resolve
    input  wire                               resValid,
    input  wire  [bpPkg::ADDR_WIDTH-1:0]      resPc,
    input  wire                               resTaken,
    input  wire                               resBack,
    input  wire  bpPkg::branchKind_e          resKind,
    // fetch
    input  wire  [bpPkg::ADDR_WIDTH-1:0]      fetchPc,
    output logic                              predHitLower,
    output logic                              predHitUpper,
    output bpPkg::branchKind_e                predKindLower,
    output bpPkg::branchKind_e                predKindUpper,
    output logic [bpPkg::ADDR_WIDTH-1:0]      predTargetLower,
    output logic [bpPkg::ADDR_WIDTH-1:0]      predTargetUpper,
    output logic                              predTakenLower,
    output logic                              predTakenUpper
);

    buildIf   bld ();
    resolveIf res ();
    fetchIf   fet ();

    logic eraseLower, eraseUpper;   // cache replace -> history wipe

    assign bld.valid       = bldValid;
    assign bld.pc          = bldPc;
    assign bld.kindLower   = bldKindLower;
    assign bld.kindUpper   = bldKindUpper;
    assign bld.targetLower = bldTargetLower;
    assign bld.targetUpper = bldTargetUpper;

    assign res.valid = resValid;
    assign res.pc    = resPc;
    assign res.taken = resTaken;
    assign res.back  = resBack;
    assign res.kind  = resKind;

    assign fet.pc = fetchPc;

    targetCache #(.SET_BITS(SET_BITS), .TAG_WIDTH(TAG_WIDTH)) cache (
        .clk        (clk),
        .rstn       (rstn),
        .build      (bld.cache),
        .resolve    (res.cache),
        .fetch      (fet.cache),
        .eraseLower (eraseLower),
        .eraseUpper (eraseUpper)
    );

    historyTable #(.HIST_IDX_BITS(HIST_IDX_BITS)) history (
        .clk        (clk),
        .rstn       (rstn),
        .build      (bld.hist),
        .resolve    (res.hist),
        .fetch      (fet.hist),
        .eraseLower (eraseLower),
        .eraseUpper (eraseUpper)
    );

    assign predHitLower    = fet.hitLower;
    assign predHitUpper    = fet.hitUpper;
    assign predKindLower   = fet.kindLower;
    assign predKindUpper   = fet.kindUpper;
    assign predTargetLower = fet.targetLower;
    assign predTargetUpper = fet.targetUpper;
    assign predTakenLower  = fet.takenLower;
    assign predTakenUpper  = fet.takenUpper;

endmodule

`default_nettype wire

// ==== verilog/historyTable.sv ====
/*
 * Per-slot history entries indexed by {set, slot bit}.
 * A resolve that hits the target cache writes init or next;
 * an erase from a replacing build wins over a resolve to the same slot.
 * Entry contents are not reset, only the valid bits.
 */
`timescale 1ns/100ps
`default_nettype none

module historyTable #(
    parameter int HIST_IDX_BITS = 6
)(
    input  wire         clk,
    input  wire         rstn,
    buildIf.hist        build,
    resolveIf.hist      resolve,
    fetchIf.hist        fetch,
    input  wire         eraseLower,
    input  wire         eraseUpper
);
    import bpPkg::*;

    localparam int ENTRIES  = 1 << HIST_IDX_BITS;
    localparam int SET_IDX  = HIST_IDX_BITS - 1;

    logic [HIST_IDX_BITS-1:0] raddr [3];        // resolve, fetch lower, fetch upper
    logic [ENTRY_WIDTH-1:0]   rdata [3];
    logic [HIST_IDX_BITS-1:0] eraseIdxLower, eraseIdxUpper;
    logic [ENTRIES-1:0]       entryValid;
    logic [ENTRY_WIDTH-1:0]   initEntry, nextEntry;
    logic                     resWrite;

    function automatic logic slotTaken(input logic hit, input branchKind_e kind,
                                       input logic vld, input logic [ENTRY_WIDTH-1:0] entry);
        logic [HIST_BITS-1:0] hist;
        hist = entry[HIST_LSB +: HIST_BITS];
        return hit && ((kind == kJump) || (vld && entry[hist * CTR_BITS + CTR_BITS - 1]));
    endfunction

    assign raddr[0] = resolve.pc[SLOT_BIT +: HIST_IDX_BITS];
    assign raddr[1] = {fetch.pc[PAIR_LSB +: SET_IDX], 1'b0};
    assign raddr[2] = {fetch.pc[PAIR_LSB +: SET_IDX], 1'b1};

    assign eraseIdxLower = {build.pc[PAIR_LSB +: SET_IDX], 1'b0};
    assign eraseIdxUpper = {build.pc[PAIR_LSB +: SET_IDX], 1'b1};

    assign resWrite = resolve.valid && resolve.hit;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            entryValid <= '0;
        end else begin
            if (resWrite) begin
                entryValid[raddr[0]] <= 1'b1;
            end
            // later writes win, so erase overrides a same-slot resolve
            if (eraseLower) begin
                entryValid[eraseIdxLower] <= 1'b0;
            end
            if (eraseUpper) begin
                entryValid[eraseIdxUpper] <= 1'b0;
            end
        end
    end

    historyNext ruleGen (
        .taken (resolve.taken),
        .back  (resolve.back),
        .kind  (resolve.kind),
        .old   (rdata[0]),
        .init  (initEntry),
        .next  (nextEntry)
    );

    asyncRam #(
        .ADDR_BITS  (HIST_IDX_BITS),
        .DATA_WIDTH (ENTRY_WIDTH),
        .READ_PORTS (3)
    ) entryRam (
        .clk   (clk),
        .wen   (resWrite),
        .waddr (raddr[0]),
        .wdata (entryValid[raddr[0]] ? nextEntry : initEntry),
        .raddr (raddr),
        .rdata (rdata)
    );

    assign fetch.takenLower = slotTaken(fetch.hitLower, fetch.kindLower,
                                        entryValid[raddr[1]], rdata[1]);
    assign fetch.takenUpper = slotTaken(fetch.hitUpper, fetch.kindUpper,
                                        entryValid[raddr[2]], rdata[2]);

endmodule

`default_nettype wire

// ==== verilog/targetCache.sv ====
/*
 * Direct-mapped target cache, one tag and one data word per slot.
 * A build whose useful slots already hit leaves the entry alone;
 * any other build replaces both slots and erases their history.
 * Fetch kinds read kNone on a miss, targets are not gated.
 */
`timescale 1ns/100ps
`default_nettype none

module targetCache #(
    parameter int SET_BITS  = 5,
    parameter int TAG_WIDTH = 24
)(
    input  wire         clk,
    input  wire         rstn,
    buildIf.cache       build,
    resolveIf.cache     resolve,
    fetchIf.cache       fetch,
    output logic        eraseLower,
    output logic        eraseUpper
);
    import bpPkg::*;

    localparam int SETS    = 1 << SET_BITS;
    localparam int TAG_LSB = PAIR_LSB + SET_BITS;

    logic [SET_BITS-1:0]   tagRaddr  [3];      // build, resolve, fetch
    logic [SET_BITS-1:0]   dataRaddr [1];
    logic [TAG_WIDTH-1:0]  tagLowerRd [3];
    logic [TAG_WIDTH-1:0]  tagUpperRd [3];
    logic [ADDR_WIDTH-1:0] dataLowerRd [1];
    logic [ADDR_WIDTH-1:0] dataUpperRd [1];
    logic [SETS-1:0]       validLower;
    logic [SETS-1:0]       validUpper;
    logic [TAG_WIDTH-1:0]  bldTag, resTag, fetTag;
    logic                  usefulLower, usefulUpper;
    logic                  bldHitLower, bldHitUpper;
    logic                  resHitLower, resHitUpper;
    logic                  replace;

    ////////////////////////////////////////////////////////////////////////////
    // lookups
    ////////////////////////////////////////////////////////////////////////////
    assign tagRaddr[0]  = build.pc[PAIR_LSB +: SET_BITS];
    assign tagRaddr[1]  = resolve.pc[PAIR_LSB +: SET_BITS];
    assign tagRaddr[2]  = fetch.pc[PAIR_LSB +: SET_BITS];
    assign dataRaddr[0] = tagRaddr[2];

    assign bldTag = build.pc[TAG_LSB +: TAG_WIDTH];
    assign resTag = resolve.pc[TAG_LSB +: TAG_WIDTH];
    assign fetTag = fetch.pc[TAG_LSB +: TAG_WIDTH];

    assign bldHitLower = validLower[tagRaddr[0]] && (tagLowerRd[0] == bldTag);
    assign bldHitUpper = validUpper[tagRaddr[0]] && (tagUpperRd[0] == bldTag);
    assign resHitLower = validLower[tagRaddr[1]] && (tagLowerRd[1] == resTag);
    assign resHitUpper = validUpper[tagRaddr[1]] && (tagUpperRd[1] == resTag);

    assign resolve.hit = resolve.pc[SLOT_BIT] ? resHitUpper : resHitLower;

    ////////////////////////////////////////////////////////////////////////////
    // build
    ////////////////////////////////////////////////////////////////////////////
    assign usefulLower = isUseful(build.kindLower);
    assign usefulUpper = isUseful(build.kindUpper);
    assign replace     = build.valid
                       && !(usefulLower && bldHitLower || usefulUpper && bldHitUpper);
    assign eraseLower  = replace;
    assign eraseUpper  = replace;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            validLower <= '0;
            validUpper <= '0;
        end else if (replace) begin
            validLower[tagRaddr[0]] <= usefulLower;
            validUpper[tagRaddr[0]] <= usefulUpper;
        end
    end

    asyncRam #(.ADDR_BITS(SET_BITS), .DATA_WIDTH(TAG_WIDTH), .READ_PORTS(3)) tagLower (
        .clk   (clk),
        .wen   (replace),
        .waddr (tagRaddr[0]),
        .wdata (bldTag),
        .raddr (tagRaddr),
        .rdata (tagLowerRd)
    );

    asyncRam #(.ADDR_BITS(SET_BITS), .DATA_WIDTH(TAG_WIDTH), .READ_PORTS(3)) tagUpper (
        .clk   (clk),
        .wen   (replace),
        .waddr (tagRaddr[0]),
        .wdata (bldTag),
        .raddr (tagRaddr),
        .rdata (tagUpperRd)
    );

    // data word is {target[31:2], kind}
    asyncRam #(.ADDR_BITS(SET_BITS), .DATA_WIDTH(ADDR_WIDTH), .READ_PORTS(1)) targetLower (
        .clk   (clk),
        .wen   (replace),
        .waddr (tagRaddr[0]),
        .wdata ({build.targetLower[ADDR_WIDTH-1:2], build.kindLower}),
        .raddr (dataRaddr),
        .rdata (dataLowerRd)
    );

    asyncRam #(.ADDR_BITS(SET_BITS), .DATA_WIDTH(ADDR_WIDTH), .READ_PORTS(1)) targetUpper (
        .clk   (clk),
        .wen   (replace),
        .waddr (tagRaddr[0]),
        .wdata ({build.targetUpper[ADDR_WIDTH-1:2], build.kindUpper}),
        .raddr (dataRaddr),
        .rdata (dataUpperRd)
    );

    ////////////////////////////////////////////////////////////////////////////
    // fetch answer
    ////////////////////////////////////////////////////////////////////////////
    assign fetch.hitLower    = validLower[tagRaddr[2]] && (tagLowerRd[2] == fetTag);
    assign fetch.hitUpper    = validUpper[tagRaddr[2]] && (tagUpperRd[2] == fetTag);
    assign fetch.kindLower   = fetch.hitLower ? branchKind_e'(dataLowerRd[0][1:0]) : kNone;
    assign fetch.kindUpper   = fetch.hitUpper ? branchKind_e'(dataUpperRd[0][1:0]) : kNone;
    assign fetch.targetLower = {dataLowerRd[0][ADDR_WIDTH-1:2], 2'b00};
    assign fetch.targetUpper = {dataUpperRd[0][ADDR_WIDTH-1:2], 2'b00};

endmodule

`default_nettype wire

// ==== verilog/historyNext.sv ====
/*
 * Next-state rules of one history entry, purely combinational.
 * init is the entry written on the first resolve of a slot,
 * next is the update of an entry that is already valid.
 */
`timescale 1ns/100ps
`default_nettype none

module historyNext (
    input  wire                             taken,
    input  wire                             back,
    input  wire  bpPkg::branchKind_e        kind,
    input  wire  [bpPkg::ENTRY_WIDTH-1:0]   old,
    output logic [bpPkg::ENTRY_WIDTH-1:0]   init,
    output logic [bpPkg::ENTRY_WIDTH-1:0]   next
);
    import bpPkg::*;

    // counters for patterns 3..0, backward loops start biased taken
    localparam logic [HIST_LSB-1:0] BACK_CTRS = {2'd2, 2'd2, 2'd2, 2'd1};
    localparam logic [HIST_LSB-1:0] FWD_CTRS  = {2'd2, 2'd1, 2'd1, 2'd1};

    logic [HIST_BITS-1:0] oldHist;
    logic [CTR_BITS-1:0]  ctr;
    logic [CTR_BITS-1:0]  newCtr;

    always_comb begin
        case (kind)
            kJump, kOther: init = '1;                         // always taken
            kCond:         init = {back, taken, back ? BACK_CTRS : FWD_CTRS};
            default:       init = '0;
        endcase
    end

    assign oldHist = old[HIST_LSB +: HIST_BITS];
    assign ctr     = old[oldHist * CTR_BITS +: CTR_BITS];

    // two-bit saturating counter
    always_comb begin
        if (taken) begin
            newCtr = (ctr == '1) ? ctr : ctr + 1'b1;
        end else begin
            newCtr = (ctr == '0) ? ctr : ctr - 1'b1;
        end
    end

    always_comb begin
        next = old;
        next[oldHist * CTR_BITS +: CTR_BITS] = newCtr;
        next[HIST_LSB +: HIST_BITS]          = {oldHist[0], taken};  // shift in outcome
    end

endmodule

`default_nettype wire

// ==== verilog/asyncRam.sv ====
/*
 * Register-array memory, one write port on the rising edge and
 * READ_PORTS independent combinational read ports.
 * A read of the written address in the write cycle sees the old data.
 * Contents are not reset.
 */
`timescale 1ns/100ps
`default_nettype none

module asyncRam #(
    parameter int ADDR_BITS  = 5,
    parameter int DATA_WIDTH = 24,
    parameter int READ_PORTS = 3
)(
    input  wire                   clk,
    input  wire                   wen,
    input  wire  [ADDR_BITS-1:0]  waddr,
    input  wire  [DATA_WIDTH-1:0] wdata,
    input  wire  [ADDR_BITS-1:0]  raddr [READ_PORTS],
    output logic [DATA_WIDTH-1:0] rdata [READ_PORTS]
);

    localparam int DEPTH = 1 << ADDR_BITS;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    for (genvar i = 0; i < READ_PORTS; i++) begin : genRead
        assign rdata[i] = mem[raddr[i]];    // async read
    end

endmodule

`default_nettype wire

// ==== verilog/bpIfs.sv ====
/*
 * Build, resolve and fetch bundles. Every valid is a one-cycle pulse
 * that is always accepted, there is no ready signal.
 */
`timescale 1ns/100ps
`default_nettype none

interface buildIf;
    import bpPkg::*;
    logic                  valid;       // decode-time build request
    logic [ADDR_WIDTH-1:0] pc;
    branchKind_e           kindLower;
    branchKind_e           kindUpper;
    logic [ADDR_WIDTH-1:0] targetLower;
    logic [ADDR_WIDTH-1:0] targetUpper;

    modport src   (output valid, pc, kindLower, kindUpper, targetLower, targetUpper);
    modport cache (input  valid, pc, kindLower, kindUpper, targetLower, targetUpper);
    modport hist  (input  pc);          // erase addressing only
endinterface

interface resolveIf;
    import bpPkg::*;
    logic                  valid;       // execute-time outcome
    logic [ADDR_WIDTH-1:0] pc;
    logic                  taken;
    logic                  back;        // backward branch
    branchKind_e           kind;
    logic                  hit;         // slot present in target cache

    modport src   (output valid, pc, taken, back, kind);
    modport cache (input  pc, output hit);
    modport hist  (input  valid, pc, taken, back, kind, hit);
endinterface

interface fetchIf;
    import bpPkg::*;
    logic [ADDR_WIDTH-1:0] pc;          // fetch pair address
    logic                  hitLower;
    logic                  hitUpper;
    branchKind_e           kindLower;
    branchKind_e           kindUpper;
    logic [ADDR_WIDTH-1:0] targetLower;
    logic [ADDR_WIDTH-1:0] targetUpper;
    logic                  takenLower;
    logic                  takenUpper;

    modport src   (output pc);
    modport cache (input  pc, output hitLower, hitUpper, kindLower, kindUpper,
                   targetLower, targetUpper);
    modport hist  (input  pc, hitLower, hitUpper, kindLower, kindUpper,
                   output takenLower, takenUpper);
endinterface

`default_nettype wire

// ==== verilog/bpPkg.sv ====
/*
 * Shared kinds, widths and field positions of the pair-fetch predictor.
 * A fetch pair is 8-byte aligned and PC bit 2 picks the slot.
 * History entry is {history[1:0], ctr3, ctr2, ctr1, ctr0}.
 */
`default_nettype none

package bpPkg;

    // branch kind recorded per slot at decode
    typedef enum logic [1:0] {
        kNone  = 2'd0,
        kCond  = 2'd1,
        kJump  = 2'd2,
        kOther = 2'd3
    } branchKind_e;

    localparam int ADDR_WIDTH  = 32;                // PC width
    localparam int HIST_BITS   = 2;                 // outcome history per slot
    localparam int CTR_BITS    = 2;                 // saturating counter width
    localparam int PATTERNS    = 1 << HIST_BITS;    // one counter per pattern
    localparam int ENTRY_WIDTH = HIST_BITS + PATTERNS * CTR_BITS;
    localparam int HIST_LSB    = ENTRY_WIDTH - HIST_BITS;  // history sits on top
    localparam int PAIR_LSB    = 3;                 // lowest set-index bit
    localparam int SLOT_BIT    = 2;                 // lower or upper slot

    // only conditional branches and jumps are worth caching
    function automatic logic isUseful(branchKind_e kind);
        return (kind == kCond) || (kind == kJump);
    endfunction

endpackage

`default_nettype wire
